// ==== common/readout_settings.svh ====
`ifndef READOUT_SETTINGS_SVH
`define READOUT_SETTINGS_SVH

// data path widths
`define READOUT_BURST_W 128 // one memory burst
`define READOUT_LINK_W 32 // one word on the link

// burst memory addressing
`define READOUT_ADDR_W 8 // 256 bursts in the burst memory
`define READOUT_CNT_W 9 // wide enough to read the whole memory in one go

// burst FIFO sizing
`define READOUT_FIFO_DEPTH 16 // entries, keep it a power of two
// almost-full threshold
// the gap to the depth covers the reads still in flight when the flag rises
`define READOUT_FIFO_AFULL 12

`endif

// ==== common/readout_pkg.sv ====
`include "readout_settings.svh"

package readout_pkg;

	//////////////////////////////////////////////////////////////////////
	// data and address types

	typedef logic [`READOUT_BURST_W-1:0] burst_t; // one 128-bit memory burst
	typedef logic [`READOUT_LINK_W-1:0] link_word_t; // one 32-bit link word
	typedef logic [`READOUT_ADDR_W-1:0] burst_addr_t; // address of a burst in memory
	typedef logic [`READOUT_CNT_W-1:0] burst_cnt_t; // number of bursts in a readout

	//////////////////////////////////////////////////////////////////////
	// state and source encodings

	// readout FSM
	typedef enum logic [1:0] {
		RD_IDLE, // waiting for a start request
		RD_READ, // issuing burst reads
		RD_DRAIN // last read issued, waiting for its FIFO write
	} reader_state_t;

	// which source owns the link
	typedef enum logic {
		SRC_CMD, // command stream, the default
		SRC_MEM // memory readout words
	} tx_src_t;

endpackage

// ==== burst_read/burst_ram.sv ====
`timescale 1ns/1ps
`include "readout_settings.svh"

// stand-in for the DDR3 fill memory
// one write port for loading, one registered read port for the reader
module burst_ram (
	input logic clk125,
	// load port
	input logic wr_en,
	input readout_pkg::burst_addr_t wr_addr,
	input readout_pkg::burst_t wr_data,
	// read port, data one cycle after rd_en
	input logic rd_en,
	input readout_pkg::burst_addr_t rd_addr,
	output readout_pkg::burst_t rd_data
);
	import readout_pkg::*;

	localparam int NUM_BURSTS = 2 ** `READOUT_ADDR_W; // 256 bursts

	burst_t mem [NUM_BURSTS]; // burst storage

	//////////////////////////////////////////////////////////////////////
	// write port

	always_ff @(posedge clk125) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data; // load while no readout runs
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read port

	// registered output, holds its value when rd_en is low
	always_ff @(posedge clk125) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// ==== burst_read/burst_reader.sv ====
`timescale 1ns/1ps

module burst_reader (
	input logic clk125,
	input logic rst_n,
	// start request
	input logic rd_start, // one-cycle pulse
	input readout_pkg::burst_addr_t rd_start_addr,
	input readout_pkg::burst_cnt_t rd_burst_cnt,
	// burst memory
	output logic ram_rd_en,
	output readout_pkg::burst_addr_t ram_rd_addr,
	input readout_pkg::burst_t ram_rd_data,
	// burst FIFO
	output logic fifo_wr_en,
	output readout_pkg::burst_t fifo_wr_data,
	output logic fifo_wr_last,
	input logic fifo_afull,
	// status
	output logic rd_done, // with the last FIFO write
	output logic readout_begin // to the mux, same cycle as the accepted start
);
	import readout_pkg::*;

	reader_state_t state_q;
	burst_addr_t addr_q; // next burst to read
	burst_cnt_t remain_q; // bursts still to be read
	logic afull_q; // registered almost-full
	logic rd_pend_q; // a read was issued last cycle
	logic last_pend_q; // ... and it was the final burst

	// start only from idle and only with something to read
	assign readout_begin = (state_q == RD_IDLE) && rd_start && (rd_burst_cnt != '0);

	// one read per cycle while the FIFO has room
	assign ram_rd_en = (state_q == RD_READ) && !afull_q;
	assign ram_rd_addr = addr_q;

	// memory data lands in the FIFO the cycle after the read
	assign fifo_wr_en = rd_pend_q;
	assign fifo_wr_data = ram_rd_data;
	assign fifo_wr_last = last_pend_q;
	assign rd_done = rd_pend_q && last_pend_q;

	//////////////////////////////////////////////////////////////////////
	// readout FSM

	always_ff @(posedge clk125) begin
		if (!rst_n) begin
			state_q <= RD_IDLE;
			addr_q <= '0;
			remain_q <= '0;
			afull_q <= 1'b0;
			rd_pend_q <= 1'b0;
			last_pend_q <= 1'b0;
		end else begin
			afull_q <= fifo_afull;
			rd_pend_q <= ram_rd_en;
			last_pend_q <= ram_rd_en && (remain_q == burst_cnt_t'(1));
			case (state_q)
				RD_IDLE: begin
					if (readout_begin) begin
						addr_q <= rd_start_addr; // wraps at the top of memory
						remain_q <= rd_burst_cnt;
						state_q <= RD_READ;
					end
				end
				RD_READ: begin
					if (ram_rd_en) begin
						addr_q <= addr_q + 1'b1;
						remain_q <= remain_q - 1'b1;
						if (remain_q == burst_cnt_t'(1)) state_q <= RD_DRAIN; // final read out
					end
				end
				RD_DRAIN: state_q <= RD_IDLE; // final burst is written this cycle
				default: state_q <= RD_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks

	// afull is registered here before it gates a read, so a write trails it by two
	a_no_write_after_afull: assert property (@(posedge clk125) disable iff (!rst_n)
		fifo_wr_en |-> !$past(fifo_afull, 2))
		else $error("burst_reader: FIFO write two cycles after almost-full");

	a_read_in_read_state: assert property (@(posedge clk125) disable iff (!rst_n)
		ram_rd_en |-> (state_q == RD_READ) && (remain_q != '0))
		else $error("burst_reader: read outside the read state");

endmodule

// ==== src/burst_fifo.sv ====
`timescale 1ns/1ps
`include "readout_settings.svh"

module burst_fifo (
	input logic clk125,
	input logic rst_n,
	// write side from the reader
	input logic wr_en,
	input readout_pkg::burst_t wr_data,
	input logic wr_last, // final burst of a readout
	output logic afull, // registered, stops new reads
	// read side, valid/ready stream
	output logic rd_valid,
	output readout_pkg::burst_t rd_data,
	output logic rd_last,
	input logic rd_ready
);
	import readout_pkg::*;

	localparam int PTR_W = $clog2(`READOUT_FIFO_DEPTH);

	burst_t data_mem [`READOUT_FIFO_DEPTH]; // burst payload
	logic last_mem [`READOUT_FIFO_DEPTH]; // last-burst marker per entry
	logic [PTR_W-1:0] wr_ptr_q; // wraps on its own, depth is a power of two
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W:0] count_q; // fill level, 0 .. depth
	logic [PTR_W:0] count_d;
	logic pop;

	assign rd_valid = (count_q != '0);
	assign rd_data = data_mem[rd_ptr_q]; // head entry
	assign rd_last = last_mem[rd_ptr_q];
	assign pop = rd_valid && rd_ready;

	always_comb begin
		count_d = count_q;
		if (wr_en && !pop) count_d = count_q + 1'b1;
		else if (!wr_en && pop) count_d = count_q - 1'b1;
	end

	always_ff @(posedge clk125) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			afull <= 1'b0;
		end else begin
			if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
			count_q <= count_d;
			afull <= (count_d >= `READOUT_FIFO_AFULL); // tracks the new fill level
		end
	end

	// storage
	always_ff @(posedge clk125) begin
		if (wr_en) begin
			data_mem[wr_ptr_q] <= wr_data;
			last_mem[wr_ptr_q] <= wr_last;
		end
	end

	// the almost-full margin must hold off the reader before the FIFO fills up
	a_no_write_full: assert property (@(posedge clk125) disable iff (!rst_n)
		wr_en |-> (count_q < `READOUT_FIFO_DEPTH))
		else $error("burst_fifo: write while full");

endmodule

// ==== link_tx/width_converter.sv ====
`timescale 1ns/1ps
`include "readout_settings.svh"

// splits a 128-bit burst into 32-bit link words, most significant first
module width_converter (
	input logic clk125,
	input logic rst_n,
	// burst stream from the FIFO
	input logic s_valid,
	input readout_pkg::burst_t s_data,
	input logic s_last,
	output logic s_ready,
	// word stream to the mux
	output logic m_valid,
	output readout_pkg::link_word_t m_data,
	output logic m_last,
	input logic m_ready
);
	import readout_pkg::*;

	localparam int WORDS = `READOUT_BURST_W / `READOUT_LINK_W; // 4 words per burst
	localparam logic [1:0] IDX_LAST = 2'(WORDS - 1);

	burst_t buf_q; // burst being shifted out
	logic last_q; // that burst ends the readout
	logic [1:0] idx_q; // word index, 0 = top word
	logic m_xfer;
	logic load;

	assign m_xfer = m_valid && m_ready;
	// take a new burst when empty or as the fourth word leaves
	assign s_ready = !m_valid || (m_xfer && (idx_q == IDX_LAST));
	assign load = s_valid && s_ready;

	//////////////////////////////////////////////////////////////////////
	// output word select

	assign m_data = buf_q[(IDX_LAST - idx_q) * `READOUT_LINK_W +: `READOUT_LINK_W];
	assign m_last = last_q && (idx_q == IDX_LAST); // only the fourth word

	//////////////////////////////////////////////////////////////////////
	// control

	always_ff @(posedge clk125) begin
		if (!rst_n) begin
			m_valid <= 1'b0;
			idx_q <= '0;
		end else if (load) begin
			m_valid <= 1'b1;
			idx_q <= '0; // restart at the top word
		end else if (m_xfer) begin
			idx_q <= idx_q + 1'b1;
			if (idx_q == IDX_LAST) m_valid <= 1'b0; // burst used up, nothing waiting
		end
	end

	// payload
	always_ff @(posedge clk125) begin
		if (load) begin
			buf_q <= s_data;
			last_q <= s_last;
		end
	end

endmodule

// ==== link_tx/link_tx_mux.sv ====
`timescale 1ns/1ps

// 2:1 stream mux in front of the link
// command stream by default, memory words from readout_begin until the last one leaves
module link_tx_mux (
	input logic clk125,
	input logic rst_n,
	input logic readout_begin, // from the reader, switch to memory
	// memory word stream
	input logic mem_valid,
	input readout_pkg::link_word_t mem_data,
	input logic mem_last,
	output logic mem_ready,
	// command stream
	input readout_pkg::link_word_t cmd_tdata,
	input logic cmd_tvalid,
	input logic cmd_tlast,
	output logic cmd_tready,
	// link
	output readout_pkg::link_word_t tx_tdata,
	output logic tx_tvalid,
	output logic tx_tlast,
	input logic tx_tready,
	input logic readout_pause // asynchronous
);
	import readout_pkg::*;

	tx_src_t src_q; // active source
	logic pause_s1; // synchronizer stages
	logic pause_s2;
	logic link_go; // link can take a word now
	logic mem_xfer;

	//////////////////////////////////////////////////////////////////////
	// pause synchronizer

	always_ff @(posedge clk125) begin
		if (!rst_n) begin
			pause_s1 <= 1'b0;
			pause_s2 <= 1'b0;
		end else begin
			pause_s1 <= readout_pause;
			pause_s2 <= pause_s1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// data path and ready steering

	assign link_go = tx_tready && !pause_s2;

	assign tx_tdata = (src_q == SRC_MEM) ? mem_data : cmd_tdata;
	assign tx_tlast = (src_q == SRC_MEM) ? mem_last : cmd_tlast;
	assign tx_tvalid = ((src_q == SRC_MEM) ? mem_valid : cmd_tvalid) && !pause_s2;

	// the idle source never sees ready, so its word waits in place
	assign mem_ready = (src_q == SRC_MEM) && link_go;
	assign cmd_tready = (src_q == SRC_CMD) && link_go;
	assign mem_xfer = mem_valid && mem_ready;

	//////////////////////////////////////////////////////////////////////
	// source select

	always_ff @(posedge clk125) begin
		if (!rst_n) begin
			src_q <= SRC_CMD;
		end else if (readout_begin) begin
			src_q <= SRC_MEM; // memory wins for the whole readout
		end else if (mem_xfer && mem_last) begin
			src_q <= SRC_CMD; // readout fully on the link
		end
	end

	// pause held through both sync stages blocks the link
	a_pause_blocks_tx: assert property (@(posedge clk125) disable iff (!rst_n)
		readout_pause [*3] |-> !tx_tvalid)
		else $error("link_tx_mux: tx_tvalid high while paused");

endmodule

// ==== src/readout_top.sv ====
`timescale 1ns/1ps

module readout_top (
	input logic clk125,
	input logic rst_n,
	// burst memory load port
	input logic ram_wr_en,
	input readout_pkg::burst_addr_t ram_wr_addr,
	input readout_pkg::burst_t ram_wr_data,
	// readout request
	input logic rd_start,
	input readout_pkg::burst_addr_t rd_start_addr,
	input readout_pkg::burst_cnt_t rd_burst_cnt,
	output logic rd_done,
	// command stream in
	input readout_pkg::link_word_t cmd_tdata,
	input logic cmd_tvalid,
	input logic cmd_tlast,
	output logic cmd_tready,
	// link stream out
	output readout_pkg::link_word_t tx_tdata,
	output logic tx_tvalid,
	output logic tx_tlast,
	input logic tx_tready,
	input logic readout_pause // async, synchronized in the mux
);
	import readout_pkg::*;

	logic ram_rd_en; // reader -> memory
	burst_addr_t ram_rd_addr;
	burst_t ram_rd_data; // memory -> reader, one cycle later
	logic fifo_wr_en; // reader -> FIFO
	burst_t fifo_wr_data;
	logic fifo_wr_last;
	logic fifo_afull; // FIFO -> reader back-pressure
	logic fifo_valid; // FIFO -> converter stream
	burst_t fifo_data;
	logic fifo_last;
	logic fifo_ready;
	logic mem_valid; // converter -> mux stream
	link_word_t mem_data;
	logic mem_last;
	logic mem_ready;
	logic readout_begin; // reader tells the mux to take the link

	//////////////////////////////////////////////////////////////////////
	// producer side

	burst_ram i_burst_ram (
		.clk125(clk125),
		.wr_en(ram_wr_en),
		.wr_addr(ram_wr_addr),
		.wr_data(ram_wr_data),
		.rd_en(ram_rd_en),
		.rd_addr(ram_rd_addr),
		.rd_data(ram_rd_data)
	);

	burst_reader i_burst_reader (
		.clk125(clk125),
		.rst_n(rst_n),
		.rd_start(rd_start),
		.rd_start_addr(rd_start_addr),
		.rd_burst_cnt(rd_burst_cnt),
		.ram_rd_data(ram_rd_data),
		.fifo_afull(fifo_afull),
		.ram_rd_en(ram_rd_en),
		.ram_rd_addr(ram_rd_addr),
		.fifo_wr_en(fifo_wr_en),
		.fifo_wr_data(fifo_wr_data),
		.fifo_wr_last(fifo_wr_last),
		.rd_done(rd_done),
		.readout_begin(readout_begin)
	);

	//////////////////////////////////////////////////////////////////////
	// buffer and consumer side

	burst_fifo i_burst_fifo (
		.clk125(clk125),
		.rst_n(rst_n),
		.wr_en(fifo_wr_en),
		.wr_data(fifo_wr_data),
		.wr_last(fifo_wr_last),
		.rd_ready(fifo_ready),
		.rd_valid(fifo_valid),
		.rd_data(fifo_data),
		.rd_last(fifo_last),
		.afull(fifo_afull)
	);

	width_converter i_width_converter (
		.clk125(clk125),
		.rst_n(rst_n),
		.s_valid(fifo_valid),
		.s_data(fifo_data),
		.s_last(fifo_last),
		.s_ready(fifo_ready),
		.m_valid(mem_valid),
		.m_data(mem_data),
		.m_last(mem_last),
		.m_ready(mem_ready)
	);

	link_tx_mux i_link_tx_mux (
		.clk125(clk125),
		.rst_n(rst_n),
		.readout_begin(readout_begin),
		.mem_valid(mem_valid),
		.mem_data(mem_data),
		.mem_last(mem_last),
		.mem_ready(mem_ready),
		.cmd_tdata(cmd_tdata),
		.cmd_tvalid(cmd_tvalid),
		.cmd_tlast(cmd_tlast),
		.cmd_tready(cmd_tready),
		.tx_tdata(tx_tdata),
		.tx_tvalid(tx_tvalid),
		.tx_tlast(tx_tlast),
		.tx_tready(tx_tready),
		.readout_pause(readout_pause)
	);

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

// 125 MHz stand-in clock at a 100 ns period, reset held low for 8 cycles
module tb_clock (
	output logic clk125,
	output logic rst_n
);
	initial begin
		clk125 = 1'b0;
		forever #50 clk125 = ~clk125; // half period
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk125);
		@(negedge clk125); // release away from the sampling edge
		rst_n = 1'b1;
	end

endmodule

// ==== verification/readout_tb.sv ====
`timescale 1ns/1ps

module readout_tb;
	import readout_pkg::*;

	// test sizes, also used for the cycle limit
	localparam int T2_MAX_BURSTS = 32;
	localparam int T3_PACKETS = 6;
	localparam int T3_MAX_LEN = 8;
	localparam int T4_BURSTS = 40; // more than the FIFO depth
	localparam int T5_BURSTS = 20;
	localparam int T5_CMD_WORDS = 8;
	localparam int T6_BURSTS = 24;
	localparam int TOTAL_WORDS = 4 * (T2_MAX_BURSTS + T4_BURSTS + T5_BURSTS + T6_BURSTS)
		+ T3_PACKETS * T3_MAX_LEN + T5_CMD_WORDS;
	localparam int CYCLE_LIMIT = 2 * TOTAL_WORDS + 2000;
	localparam int READY_LOW = 0; // tx_tready modes
	localparam int READY_HIGH = 1;
	localparam int READY_RANDOM = 2;

	logic clk125, rst_n;
	logic ram_wr_en, rd_start, rd_done;
	burst_addr_t ram_wr_addr, rd_start_addr;
	burst_t ram_wr_data;
	burst_cnt_t rd_burst_cnt;
	link_word_t cmd_tdata, tx_tdata;
	logic cmd_tvalid, cmd_tlast, cmd_tready;
	logic tx_tvalid, tx_tlast, tx_tready, readout_pause;

	integer seed = 32'h6ed3_fdb9;
	int error_count = 0;
	int cycle_count = 0;
	int rd_done_count = 0;
	int done_at_start = 0; // rd_done_count when the current readout began
	int ready_mode = READY_LOW;
	string test_name = "reset";
	burst_t model_mem [256]; // copy of the burst memory
	logic [32:0] exp_mem [$]; // {last, word} expected from the readout
	logic [32:0] exp_cmd [$]; // {last, word} command words offered
	logic src_mem = 1'b0; // model of the mux source, 1 = memory
	logic pause_check = 1'b0; // pause has settled, tx must stay quiet

	tb_clock i_tb_clock (.clk125(clk125), .rst_n(rst_n));

	readout_top i_dut (
		.clk125(clk125), .rst_n(rst_n),
		.ram_wr_en(ram_wr_en), .ram_wr_addr(ram_wr_addr), .ram_wr_data(ram_wr_data),
		.rd_start(rd_start), .rd_start_addr(rd_start_addr), .rd_burst_cnt(rd_burst_cnt),
		.rd_done(rd_done),
		.cmd_tdata(cmd_tdata), .cmd_tvalid(cmd_tvalid), .cmd_tlast(cmd_tlast),
		.cmd_tready(cmd_tready),
		.tx_tdata(tx_tdata), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast),
		.tx_tready(tx_tready), .readout_pause(readout_pause)
	);

	//////////////////////////////////////////////////////////////////////
	// helpers

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// fill the whole memory and the model with random bursts
	task automatic load_memory();
		for (int a = 0; a < 256; a++) begin
			@(negedge clk125);
			ram_wr_en = 1'b1;
			ram_wr_addr = burst_addr_t'(a);
			ram_wr_data = {$random(seed), $random(seed), $random(seed), $random(seed)};
			model_mem[a] = ram_wr_data;
		end
		@(negedge clk125);
		ram_wr_en = 1'b0;
	endtask

	// queue the expected words, then pulse rd_start
	task automatic start_readout(input burst_addr_t addr, input int cnt);
		burst_t burst;
		burst_addr_t a;
		for (int b = 0; b < cnt; b++) begin
			a = addr + burst_addr_t'(b); // memory wraps at the top
			burst = model_mem[a];
			for (int w = 0; w < 4; w++) begin
				exp_mem.push_back({(b == cnt - 1) && (w == 3),
					link_word_t'(burst >> (32 * (3 - w)))}); // top word first
			end
		end
		@(negedge clk125);
		done_at_start = rd_done_count;
		rd_start = 1'b1;
		rd_start_addr = addr;
		rd_burst_cnt = burst_cnt_t'(cnt);
		@(negedge clk125);
		rd_start = 1'b0;
	endtask

	// wait until the last memory word has left and the source is back on command
	task automatic finish_readout();
		while ((exp_mem.size() != 0) || src_mem) @(negedge clk125);
		check_value({test_name, " rd_done count"}, 1, rd_done_count - done_at_start);
	endtask

	task automatic send_cmd_packet(input int len);
		for (int i = 0; i < len; i++) begin
			@(negedge clk125);
			cmd_tdata = $random(seed);
			cmd_tlast = (i == len - 1);
			cmd_tvalid = 1'b1;
			exp_cmd.push_back({cmd_tlast, cmd_tdata});
			@(posedge clk125);
			while (!cmd_tready) @(posedge clk125); // held until accepted
		end
		@(negedge clk125);
		cmd_tvalid = 1'b0;
		cmd_tlast = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// link side: ready driver, monitor and timeout

	always @(negedge clk125) begin
		case (ready_mode)
			READY_HIGH: tx_tready = 1'b1;
			READY_RANDOM: tx_tready = $random(seed) & 1; // about half the cycles
			default: tx_tready = 1'b0;
		endcase
	end

	always @(posedge clk125) begin : monitor
		logic [32:0] exp_word;
		if (rst_n) begin
			if (rd_done) rd_done_count++;
			if (pause_check && tx_tvalid) begin
				error_count++;
				$display("%s: tx_tvalid high while the pause is held", test_name);
			end
			if (src_mem && cmd_tvalid && cmd_tready) begin
				error_count++;
				$display("%s: command word accepted during a readout", test_name);
			end
			if (tx_tvalid && tx_tready) begin
				if (src_mem) begin // memory owns the link
					if (exp_mem.size() == 0) begin
						error_count++;
						$display("%s: memory word on tx with none expected", test_name);
					end else begin
						exp_word = exp_mem.pop_front();
						check_value({test_name, " mem word"}, exp_word, {tx_tlast, tx_tdata});
						if (exp_word[32]) src_mem = 1'b0; // back to command next cycle
					end
				end else if (exp_cmd.size() == 0) begin
					error_count++;
					$display("%s: command word on tx with none offered", test_name);
				end else begin
					check_value({test_name, " cmd word"}, exp_cmd.pop_front(),
						{tx_tlast, tx_tdata});
				end
			end
			if (rd_start && (rd_burst_cnt != '0) && !src_mem) src_mem = 1'b1; // accepted
		end
	end

	always @(posedge clk125) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d", error_count);
			$display("test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		ram_wr_en = 1'b0;
		ram_wr_addr = '0;
		ram_wr_data = '0;
		rd_start = 1'b0;
		rd_start_addr = '0;
		rd_burst_cnt = '0;
		cmd_tdata = '0;
		cmd_tvalid = 1'b0;
		cmd_tlast = 1'b0;
		tx_tready = 1'b0;
		readout_pause = 1'b0;

		// 1: quiet outputs after reset, tx_tready still low
		@(posedge rst_n);
		@(negedge clk125);
		check_value("reset tx_tvalid", 0, tx_tvalid);
		check_value("reset cmd_tready", 0, cmd_tready);
		check_value("reset rd_done", 0, rd_done);
		ready_mode = READY_HIGH;

		// 2: random contents, random address and count
		test_name = "random_readout";
		load_memory();
		start_readout($random(seed), 1 + ($unsigned($random(seed)) % T2_MAX_BURSTS));
		finish_readout();

		// 3: command packets with no readout running
		test_name = "cmd_packets";
		for (int p = 0; p < T3_PACKETS; p++) begin
			send_cmd_packet(1 + ($unsigned($random(seed)) % T3_MAX_LEN));
		end
		while (exp_cmd.size() != 0) @(negedge clk125);

		// 4: long readout against random back-pressure
		test_name = "backpressure";
		ready_mode = READY_RANDOM;
		start_readout($random(seed), T4_BURSTS);
		finish_readout();
		ready_mode = READY_HIGH;

		// 5: command words wait for the end of the readout
		test_name = "cmd_during_readout";
		start_readout($random(seed), T5_BURSTS);
		fork
			finish_readout();
			send_cmd_packet(T5_CMD_WORDS);
		join
		while (exp_cmd.size() != 0) @(negedge clk125);

		// 6: pause in the middle of a readout
		test_name = "pause";
		start_readout($random(seed), T6_BURSTS);
		repeat (5) @(negedge clk125);
		readout_pause = 1'b1;
		repeat (3) @(posedge clk125); // through the synchronizer
		@(negedge clk125);
		pause_check = 1'b1;
		repeat (20) @(negedge clk125);
		pause_check = 1'b0;
		readout_pause = 1'b0;
		finish_readout();

		repeat (4) @(negedge clk125);
		$display("errors: %0d", error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== readout_top.f ====
+incdir+common
common/readout_pkg.sv
burst_read/burst_ram.sv
burst_read/burst_reader.sv
src/burst_fifo.sv
link_tx/width_converter.sv
link_tx/link_tx_mux.sv
src/readout_top.sv
verification/tb_clock.sv
verification/readout_tb.sv

// ==== Bender.yml ====
package:
  name: readout

sources:
  # package and RTL, the package pulls in the settings header
  - include_dirs:
      - common
    files:
      - common/readout_pkg.sv
      - burst_read/burst_ram.sv
      - burst_read/burst_reader.sv
      - src/burst_fifo.sv
      - link_tx/width_converter.sv
      - link_tx/link_tx_mux.sv
      - src/readout_top.sv

  # testbench
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/readout_tb.sv
